// File: source/dcache_pkg.sv
package dcache_pkg;

    // request address is tag, index and byte offset
    localparam int ADDR_W   = 32;
    localparam int TAG_W    = 23;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 3;

    // one 64-bit word per line
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;

    localparam int NUM_SETS = 64;
    localparam int NUM_WAYS = 2;
    localparam int WAY_W    = 1;

    // per-line saturating age where larger is older
    localparam int AGE_W   = 3;
    localparam int AGE_MAX = 7;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        HIT,
        WRITEBACK,
        REFILL
    } state_t;

    // kind of request held toward memory
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_WRITEBACK,
        MEM_REFILL
    } mem_op_t;

endpackage

// File: source/dcache_way_if.sv
`timescale 1ns/1ps

interface dcache_way_if (
    input logic clk
);
    // lookup and write side, from the controller
    logic [dcache_pkg::INDEX_W-1:0] index;
    logic [dcache_pkg::TAG_W-1:0]   tag;
    logic                           wr_en;
    logic [dcache_pkg::DATA_W-1:0]  wr_data;
    logic [dcache_pkg::STRB_W-1:0]  wr_strb;
    logic                           fill;
    logic                           mark_dirty;
    logic                           clean;
    logic                           touch;

    // status of the addressed line, one cycle after index
    logic                           hit;
    logic                           valid;
    logic                           dirty;
    logic [dcache_pkg::TAG_W-1:0]   stored_tag;
    logic [dcache_pkg::DATA_W-1:0]  rd_data;
    logic [dcache_pkg::AGE_W-1:0]   age;

    modport ctrl (
        output index, tag, wr_en, wr_data, wr_strb, fill, mark_dirty, clean, touch,
        input  valid, dirty, stored_tag, rd_data
    );

    modport way (
        input  index, tag, wr_en, wr_data, wr_strb, fill, mark_dirty, clean, touch,
        output hit, valid, dirty, stored_tag, rd_data, age
    );

    modport sel (
        input clk, hit, valid, rd_data, age
    );

endinterface

// File: source/dcache_way.sv
`timescale 1ns/1ps

module dcache_way (
    input logic        clk,
    input logic        rst_n_i,
    dcache_way_if.way  port
);

    logic [dcache_pkg::TAG_W-1:0]  tag_mem  [dcache_pkg::NUM_SETS];
    logic [dcache_pkg::DATA_W-1:0] data_mem [dcache_pkg::NUM_SETS];
    logic [dcache_pkg::AGE_W-1:0]  age_q    [dcache_pkg::NUM_SETS];
    logic [dcache_pkg::NUM_SETS-1:0] valid_q;
    logic [dcache_pkg::NUM_SETS-1:0] dirty_q;

    logic                          hit_q;
    logic                          valid_rd_q;
    logic                          dirty_rd_q;
    logic [dcache_pkg::AGE_W-1:0]  age_rd_q;
    logic [dcache_pkg::TAG_W-1:0]  tag_rd_q;
    logic [dcache_pkg::DATA_W-1:0] data_rd_q;

    // data and tag arrays
    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
                if (port.wr_strb[b]) begin
                    data_mem[port.index][b*8 +: 8] <= port.wr_data[b*8 +: 8];
                end
            end
            if (port.fill) begin
                tag_mem[port.index] <= port.tag;
            end
        end
        data_rd_q <= data_mem[port.index];
        tag_rd_q  <= tag_mem[port.index];
    end

    // line state and registered lookup
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q    <= '0;
            dirty_q    <= '0;
            for (int s = 0; s < dcache_pkg::NUM_SETS; s++) begin
                age_q[s] <= '0;
            end
            hit_q      <= 1'b0;
            valid_rd_q <= 1'b0;
            dirty_rd_q <= 1'b0;
            age_rd_q   <= '0;
        end else begin
            if (port.wr_en && port.fill) begin
                valid_q[port.index] <= 1'b1;
            end
            if (port.clean || port.fill) begin
                dirty_q[port.index] <= 1'b0;
            end
            if (port.mark_dirty) begin
                dirty_q[port.index] <= 1'b1;
            end
            // target line becomes youngest, the rest age by one
            if (port.touch) begin
                if (port.wr_en || hit_q) begin
                    age_q[port.index] <= '0;
                end else if (age_q[port.index] != dcache_pkg::AGE_W'(dcache_pkg::AGE_MAX)) begin
                    age_q[port.index] <= age_q[port.index] + 1'b1;
                end
            end
            hit_q      <= valid_q[port.index] && (tag_mem[port.index] == port.tag);
            valid_rd_q <= valid_q[port.index];
            dirty_rd_q <= dirty_q[port.index];
            age_rd_q   <= age_q[port.index];
        end
    end

    assign port.hit        = hit_q;
    assign port.valid      = valid_rd_q;
    assign port.dirty      = dirty_rd_q;
    assign port.age        = age_rd_q;
    assign port.stored_tag = tag_rd_q;
    assign port.rd_data    = data_rd_q;

    // a fill only ever comes with its data write
    assert property (@(posedge clk) disable iff (!rst_n_i)
        port.fill |-> port.wr_en);

endmodule

// File: source/dcache_way_select.sv
`timescale 1ns/1ps

module dcache_way_select (
    dcache_way_if.sel                     ways [dcache_pkg::NUM_WAYS],
    output logic                          hit_o,
    output logic [dcache_pkg::WAY_W-1:0]  hit_way_o,
    output logic [dcache_pkg::WAY_W-1:0]  victim_way_o,
    output logic [dcache_pkg::DATA_W-1:0] rdata_o
);

    logic [dcache_pkg::NUM_WAYS-1:0] way_hit;
    logic [dcache_pkg::NUM_WAYS-1:0] way_valid;
    logic [dcache_pkg::AGE_W-1:0]    way_age  [dcache_pkg::NUM_WAYS];
    logic [dcache_pkg::DATA_W-1:0]   way_data [dcache_pkg::NUM_WAYS];
    logic [dcache_pkg::AGE_W-1:0]    oldest_age;

    for (genvar g = 0; g < dcache_pkg::NUM_WAYS; g++) begin : g_way
        assign way_hit[g]   = ways[g].hit;
        assign way_valid[g] = ways[g].valid;
        assign way_age[g]   = ways[g].age;
        assign way_data[g]  = ways[g].rd_data;
    end

    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_way_o = dcache_pkg::WAY_W'(w);
            end
        end
    end

    assign hit_o   = |way_hit;
    assign rdata_o = way_data[hit_way_o];

    // oldest line wins and ties stay with the lower way
    always_comb begin
        victim_way_o = '0;
        oldest_age   = way_age[0];
        for (int w = 1; w < dcache_pkg::NUM_WAYS; w++) begin
            if (way_age[w] > oldest_age) begin
                oldest_age   = way_age[w];
                victim_way_o = dcache_pkg::WAY_W'(w);
            end
        end
        // lowest invalid way overrides
        for (int w = dcache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (!way_valid[w]) begin
                victim_way_o = dcache_pkg::WAY_W'(w);
            end
        end
    end

    // tags of one set never repeat across ways
    assert property (@(posedge ways[0].clk) $onehot0(way_hit));

endmodule

// File: source/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          read_valid_i,
    input  logic                          write_valid_i,
    input  logic [dcache_pkg::ADDR_W-1:0] addr_i,
    input  logic [dcache_pkg::DATA_W-1:0] wdata_i,
    input  logic [dcache_pkg::STRB_W-1:0] wstrb_i,
    output logic                          ready_o,
    output logic                          done_o,
    output logic [dcache_pkg::DATA_W-1:0] rdata_o,
    output dcache_pkg::mem_op_t           mem_op_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_addr_o,
    output logic [dcache_pkg::DATA_W-1:0] mem_wdata_o,
    input  logic                          mem_ack_i,
    input  logic [dcache_pkg::DATA_W-1:0] mem_rdata_i,
    input  logic                          hit_i,
    input  logic [dcache_pkg::WAY_W-1:0]  hit_way_i,
    input  logic [dcache_pkg::WAY_W-1:0]  victim_way_i,
    input  logic [dcache_pkg::DATA_W-1:0] hit_data_i,
    dcache_way_if.ctrl                    ways [dcache_pkg::NUM_WAYS]
);

    dcache_pkg::state_t state_q;
    dcache_pkg::state_t state_d;

    logic                            accept;
    logic                            req_write_q;
    logic [dcache_pkg::ADDR_W-1:0]   req_addr_q;
    logic [dcache_pkg::DATA_W-1:0]   req_wdata_q;
    logic [dcache_pkg::STRB_W-1:0]   req_strb_q;
    logic [dcache_pkg::INDEX_W-1:0]  req_index;
    logic [dcache_pkg::TAG_W-1:0]    req_tag;

    logic [dcache_pkg::NUM_WAYS-1:0] way_valid;
    logic [dcache_pkg::NUM_WAYS-1:0] way_dirty;
    logic [dcache_pkg::TAG_W-1:0]    way_tag  [dcache_pkg::NUM_WAYS];
    logic [dcache_pkg::DATA_W-1:0]   way_data [dcache_pkg::NUM_WAYS];
    logic                            victim_dirty;

    logic [dcache_pkg::WAY_W-1:0]    target_way;
    logic                            wr_en;
    logic                            fill;
    logic                            mark_dirty;
    logic                            clean;
    logic                            touch;
    logic [dcache_pkg::DATA_W-1:0]   wr_data;
    logic [dcache_pkg::STRB_W-1:0]   wr_strb;

    assign ready_o   = (state_q == dcache_pkg::IDLE);
    assign accept    = ready_o && (read_valid_i || write_valid_i);
    assign req_index = req_addr_q[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    assign req_tag   = req_addr_q[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];

    // write wins when both strobes are up
    always_ff @(posedge clk) begin
        if (accept) begin
            req_write_q <= write_valid_i;
            req_addr_q  <= addr_i;
            req_wdata_q <= wdata_i;
            req_strb_q  <= wstrb_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= dcache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::IDLE:      if (accept) state_d = dcache_pkg::LOOKUP;
            dcache_pkg::LOOKUP:    state_d = dcache_pkg::HIT;
            dcache_pkg::HIT: begin
                if (hit_i) begin
                    state_d = dcache_pkg::IDLE;
                end else if (victim_dirty) begin
                    state_d = dcache_pkg::WRITEBACK;
                end else begin
                    state_d = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::WRITEBACK: if (mem_ack_i) state_d = dcache_pkg::REFILL;
            dcache_pkg::REFILL:    if (mem_ack_i) state_d = dcache_pkg::LOOKUP;
            default:               state_d = dcache_pkg::IDLE;
        endcase
    end

    for (genvar g = 0; g < dcache_pkg::NUM_WAYS; g++) begin : g_way
        assign way_valid[g] = ways[g].valid;
        assign way_dirty[g] = ways[g].dirty;
        assign way_tag[g]   = ways[g].stored_tag;
        assign way_data[g]  = ways[g].rd_data;

        assign ways[g].index      = req_index;
        assign ways[g].tag        = req_tag;
        assign ways[g].wr_data    = wr_data;
        assign ways[g].wr_strb    = wr_strb;
        assign ways[g].touch      = touch;
        // enables only reach the target way
        assign ways[g].wr_en      = wr_en && (target_way == dcache_pkg::WAY_W'(g));
        assign ways[g].fill       = fill && (target_way == dcache_pkg::WAY_W'(g));
        assign ways[g].mark_dirty = mark_dirty && (target_way == dcache_pkg::WAY_W'(g));
        assign ways[g].clean      = clean && (target_way == dcache_pkg::WAY_W'(g));
    end

    assign victim_dirty = way_valid[victim_way_i] && way_dirty[victim_way_i];

    // the way merges the strobed bytes into the stored word
    always_comb begin
        target_way = (state_q == dcache_pkg::HIT) ? hit_way_i : victim_way_i;
        wr_en      = 1'b0;
        fill       = 1'b0;
        mark_dirty = 1'b0;
        clean      = 1'b0;
        touch      = 1'b0;
        wr_data    = req_wdata_q;
        wr_strb    = req_strb_q;
        if (state_q == dcache_pkg::HIT && hit_i) begin
            touch      = 1'b1;
            wr_en      = req_write_q;
            mark_dirty = req_write_q;
        end else if (state_q == dcache_pkg::WRITEBACK) begin
            clean = mem_ack_i;
        end else if (state_q == dcache_pkg::REFILL && mem_ack_i) begin
            wr_en   = 1'b1;
            fill    = 1'b1;
            wr_data = mem_rdata_i;
            wr_strb = '1;
        end
    end

    always_comb begin
        mem_op_o    = dcache_pkg::MEM_NONE;
        mem_addr_o  = '0;
        mem_wdata_o = '0;
        case (state_q)
            dcache_pkg::WRITEBACK: begin
                mem_op_o    = dcache_pkg::MEM_WRITEBACK;
                mem_addr_o  = {way_tag[victim_way_i], req_index, {dcache_pkg::OFFSET_W{1'b0}}};
                mem_wdata_o = way_data[victim_way_i];
            end
            dcache_pkg::REFILL: begin
                mem_op_o   = dcache_pkg::MEM_REFILL;
                mem_addr_o = {req_tag, req_index, {dcache_pkg::OFFSET_W{1'b0}}};
            end
            default: begin
                mem_op_o = dcache_pkg::MEM_NONE;
            end
        endcase
    end

    assign done_o  = (state_q == dcache_pkg::HIT) && hit_i;
    assign rdata_o = (done_o && !req_write_q) ? hit_data_i : '0;

    // memory request held until acknowledged
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (mem_op_o != dcache_pkg::MEM_NONE && !mem_ack_i) |=>
            ($stable(mem_op_o) && $stable(mem_addr_o) && $stable(mem_wdata_o)));

    // a hit completes right after its lookup and leaves the cache ready
    assert property (@(posedge clk) disable iff (!rst_n_i)
        done_o |-> ($past(state_q) == dcache_pkg::LOOKUP) ##1 ready_o);

endmodule

// File: source/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          read_valid_i,
    input  logic                          write_valid_i,
    input  logic [dcache_pkg::ADDR_W-1:0] addr_i,
    input  logic [dcache_pkg::DATA_W-1:0] wdata_i,
    input  logic [dcache_pkg::STRB_W-1:0] wstrb_i,
    output logic                          ready_o,
    output logic                          done_o,
    output logic [dcache_pkg::DATA_W-1:0] rdata_o,
    output dcache_pkg::mem_op_t           mem_op_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_addr_o,
    output logic [dcache_pkg::DATA_W-1:0] mem_wdata_o,
    input  logic                          mem_ack_i,
    input  logic [dcache_pkg::DATA_W-1:0] mem_rdata_i
);

    logic                          hit;
    logic [dcache_pkg::WAY_W-1:0]  hit_way;
    logic [dcache_pkg::WAY_W-1:0]  victim_way;
    logic [dcache_pkg::DATA_W-1:0] hit_data;

    dcache_way_if way_if [dcache_pkg::NUM_WAYS] (.clk(clk));

    dcache_ctrl dcache_ctrl_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .read_valid_i  (read_valid_i),
        .write_valid_i (write_valid_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .wstrb_i       (wstrb_i),
        .ready_o       (ready_o),
        .done_o        (done_o),
        .rdata_o       (rdata_o),
        .mem_op_o      (mem_op_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_ack_i     (mem_ack_i),
        .mem_rdata_i   (mem_rdata_i),
        .hit_i         (hit),
        .hit_way_i     (hit_way),
        .victim_way_i  (victim_way),
        .hit_data_i    (hit_data),
        .ways          (way_if)
    );

    for (genvar g = 0; g < dcache_pkg::NUM_WAYS; g++) begin : g_way
        dcache_way dcache_way_inst (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .port    (way_if[g])
        );
    end

    dcache_way_select dcache_way_select_inst (
        .ways         (way_if),
        .hit_o        (hit),
        .hit_way_o    (hit_way),
        .victim_way_o (victim_way),
        .rdata_o      (hit_data)
    );

endmodule

// File: tb/dcache_checker.sv
`timescale 1ns/1ps

module dcache_checker (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          read_valid_i,
    input  logic                          write_valid_i,
    input  logic [dcache_pkg::ADDR_W-1:0] addr_i,
    input  logic [dcache_pkg::DATA_W-1:0] wdata_i,
    input  logic [dcache_pkg::STRB_W-1:0] wstrb_i,
    input  logic                          ready_i,
    input  logic                          done_i,
    input  logic [dcache_pkg::DATA_W-1:0] rdata_i,
    input  dcache_pkg::mem_op_t           mem_op_i,
    input  logic [dcache_pkg::ADDR_W-1:0] mem_addr_i,
    input  logic [dcache_pkg::DATA_W-1:0] mem_wdata_i,
    input  logic                          mem_ack_i,
    input  logic                          expect_hit_i,
    input  logic                          expect_miss_i,
    input  logic                          expect_wb_i,
    input  logic [dcache_pkg::ADDR_W-1:0] wb_addr_i,
    output int                            check_count_o,
    output int                            error_count_o
);

    // written bytes of the expected memory
    logic [7:0]  ref_bytes [logic [31:0]];

    int          checks = 0;
    int          errors = 0;
    logic        reset_seen = 1'b0;
    logic        busy = 1'b0;
    int          cycles;
    logic        req_write;
    logic [31:0] req_addr;
    logic        exp_hit;
    logic        exp_miss;
    logic        exp_wb;
    logic [31:0] exp_wb_addr;
    logic        wb_seen;
    logic        refill_seen;

    assign check_count_o = checks;
    assign error_count_o = errors;

    // backing memory contents before any write
    function automatic logic [63:0] initial_word(input logic [31:0] base);
        return {base ^ 32'hc3a5_1e77, ~base + 32'h0101_0101};
    endfunction

    function automatic logic [63:0] expected_word(input logic [31:0] addr);
        logic [31:0] base;
        logic [63:0] word;
        base = {addr[31:3], 3'b000};
        word = initial_word(base);
        for (int b = 0; b < 8; b++) begin
            if (ref_bytes.exists(base + 32'(b))) begin
                word[b*8 +: 8] = ref_bytes[base + 32'(b)];
            end
        end
        return word;
    endfunction

    task automatic apply_write(input logic [31:0] addr, input logic [63:0] data,
                               input logic [7:0] strb);
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                ref_bytes[{addr[31:3], 3'b000} + 32'(b)] = data[b*8 +: 8];
            end
        end
    endtask

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic complain(input string what);
        checks++;
        errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    always @(posedge clk) begin
        if (rst_n_i) begin
            if (!reset_seen) begin
                reset_seen = 1'b1;
                compare("ready_o", 64'd1, 64'(ready_i));
                compare("done_o", 64'd0, 64'(done_i));
                compare("mem_op_o", 64'(dcache_pkg::MEM_NONE), 64'(mem_op_i));
            end
            if (mem_op_i != dcache_pkg::MEM_NONE && !busy) begin
                complain("memory request while no request is outstanding");
            end
            // request fields are still held in the ack cycle
            if (mem_op_i == dcache_pkg::MEM_WRITEBACK && mem_ack_i) begin
                wb_seen = 1'b1;
                compare("mem_wdata_o", expected_word(mem_addr_i), mem_wdata_i);
                compare("mem_addr_o", 64'({mem_addr_i[31:9], req_addr[8:3], 3'b000}),
                        64'(mem_addr_i));
                if (exp_wb) begin
                    compare("mem_addr_o", 64'(exp_wb_addr), 64'(mem_addr_i));
                end
            end
            if (mem_op_i == dcache_pkg::MEM_REFILL && mem_ack_i) begin
                refill_seen = 1'b1;
                compare("mem_addr_o", 64'({req_addr[31:3], 3'b000}), 64'(mem_addr_i));
            end
            if (busy) begin
                cycles++;
                if (done_i) begin
                    busy = 1'b0;
                    compare("rdata_o", req_write ? 64'd0 : expected_word(req_addr), rdata_i);
                    if (exp_hit && (cycles != 2 || wb_seen || refill_seen)) begin
                        complain("hit did not complete two cycles after acceptance");
                    end
                    if (exp_miss && !refill_seen) begin
                        complain("miss completed without a refill");
                    end
                    if (exp_miss && !exp_wb && wb_seen) begin
                        complain("write-back of a clean victim");
                    end
                    if (exp_wb && !wb_seen) begin
                        complain("dirty victim was not written back");
                    end
                end
            end else if (done_i) begin
                complain("done_o without an outstanding request");
            end
            if (ready_i && (read_valid_i || write_valid_i)) begin
                busy        = 1'b1;
                cycles      = 0;
                wb_seen     = 1'b0;
                refill_seen = 1'b0;
                req_write   = write_valid_i;
                req_addr    = addr_i;
                exp_hit     = expect_hit_i;
                exp_miss    = expect_miss_i;
                exp_wb      = expect_wb_i;
                exp_wb_addr = wb_addr_i;
                if (write_valid_i) begin
                    apply_write(addr_i, wdata_i, wstrb_i);
                end
            end
        end
    end

endmodule

// File: tb/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

    localparam int          CLK_PERIOD     = 100;
    localparam int          RANDOM_REQS    = 200;
    localparam int          TOTAL_REQS     = RANDOM_REQS + 11;
    localparam int          TIMEOUT_CYCLES = TOTAL_REQS * 20 + 40;
    localparam logic [31:0] SEED           = 32'hd6c94d6a;

    logic                clk;
    logic                rst_n_i;
    logic                read_valid_i;
    logic                write_valid_i;
    logic [31:0]         addr_i;
    logic [63:0]         wdata_i;
    logic [7:0]          wstrb_i;
    logic                ready_o;
    logic                done_o;
    logic [63:0]         rdata_o;
    dcache_pkg::mem_op_t mem_op_o;
    logic [31:0]         mem_addr_o;
    logic [63:0]         mem_wdata_o;
    logic                mem_ack_i;
    logic [63:0]         mem_rdata_i;

    logic                expect_hit;
    logic                expect_miss;
    logic                expect_wb;
    logic [31:0]         wb_addr;
    int                  check_count;
    int                  error_count;
    int                  tests_run = 0;
    int                  tests_failed = 0;
    int                  errors_before = 0;
    logic [63:0]         mem_model [logic [31:0]];

    dcache_top dcache_top_inst (.*);

    dcache_checker dcache_checker_inst (
        .clk (clk), .rst_n_i (rst_n_i), .read_valid_i (read_valid_i),
        .write_valid_i (write_valid_i), .addr_i (addr_i), .wdata_i (wdata_i),
        .wstrb_i (wstrb_i), .ready_i (ready_o), .done_i (done_o), .rdata_i (rdata_o),
        .mem_op_i (mem_op_o), .mem_addr_i (mem_addr_o), .mem_wdata_i (mem_wdata_o),
        .mem_ack_i (mem_ack_i), .expect_hit_i (expect_hit), .expect_miss_i (expect_miss),
        .expect_wb_i (expect_wb), .wb_addr_i (wb_addr), .check_count_o (check_count),
        .error_count_o (error_count)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'hd000_0001) : (state >> 1);
    endfunction

    // one LFSR step per bit taken
    task automatic draw_bits(inout logic [31:0] state, input int count,
                             output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], state[0]};
            state = lfsr_next(state);
        end
    endtask

    function automatic logic [63:0] read_memory(input logic [31:0] addr);
        if (mem_model.exists(addr)) begin
            return mem_model[addr];
        end
        return {addr ^ 32'hc3a5_1e77, ~addr + 32'h0101_0101};
    endfunction

    function automatic logic [31:0] make_addr(input logic [22:0] tag, input logic [5:0] set,
                                              input logic [2:0] offset);
        return {tag, set, offset};
    endfunction

    task automatic run_request(input logic wr, input logic [31:0] addr, input logic [63:0] data,
                               input logic [7:0] strb, input logic hit, input logic miss,
                               input logic wb, input logic [31:0] victim_addr);
        read_valid_i  <= !wr;
        write_valid_i <= wr;
        addr_i        <= addr;
        wdata_i       <= data;
        wstrb_i       <= strb;
        expect_hit    <= hit;
        expect_miss   <= miss;
        expect_wb     <= wb;
        wb_addr       <= victim_addr;
        @(posedge clk);
        while (!ready_o) @(posedge clk);
        read_valid_i  <= 1'b0;
        write_valid_i <= 1'b0;
        @(posedge clk);
        while (!done_o) @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        int errors;
        @(negedge clk);
        errors = error_count - errors_before;
        errors_before = error_count;
        tests_run++;
        if (errors != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (errors == 0) ? "passed" : "failed", errors);
        @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // memory answers after 0 to 3 idle cycles
    initial begin
        logic [31:0] lfsr;
        logic [31:0] delay;
        logic        pending;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        lfsr        = SEED;
        pending     = 1'b0;
        delay       = '0;
        forever begin
            @(posedge clk);
            if (mem_ack_i) begin
                mem_ack_i <= 1'b0;
            end else if (mem_op_o != dcache_pkg::MEM_NONE) begin
                if (!pending) begin
                    draw_bits(lfsr, 2, delay);
                    pending = 1'b1;
                end
                if (delay == 0) begin
                    pending = 1'b0;
                    mem_ack_i <= 1'b1;
                    if (mem_op_o == dcache_pkg::MEM_WRITEBACK) begin
                        mem_model[mem_addr_o] = mem_wdata_o;
                    end else begin
                        mem_rdata_i <= read_memory(mem_addr_o);
                    end
                end else begin
                    delay = delay - 1;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: requests did not complete after %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0] lfsr;
        logic [31:0] tag;
        logic [31:0] set;
        logic [31:0] offset;
        logic [31:0] wr;
        logic [31:0] lo;
        logic [31:0] hi;
        logic [31:0] strb;
        rst_n_i       = 1'b0;
        read_valid_i  = 1'b0;
        write_valid_i = 1'b0;
        addr_i        = '0;
        wdata_i       = '0;
        wstrb_i       = '0;
        expect_hit    = 1'b0;
        expect_miss   = 1'b0;
        expect_wb     = 1'b0;
        wb_addr       = '0;
        lfsr          = SEED;
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        @(posedge clk);
        finish_test("reset values");

        run_request(1'b0, make_addr(23'h1234, 6'd5, 3'd4), '0, '0, 1'b0, 1'b1, 1'b0, '0);
        finish_test("read miss refill");

        run_request(1'b0, make_addr(23'h1234, 6'd5, 3'd0), '0, '0, 1'b1, 1'b0, 1'b0, '0);
        run_request(1'b1, make_addr(23'h1234, 6'd5, 3'd4), 64'h0123_4567_89ab_cdef, 8'hff,
                    1'b1, 1'b0, 1'b0, '0);
        run_request(1'b0, make_addr(23'h1234, 6'd5, 3'd2), '0, '0, 1'b1, 1'b0, 1'b0, '0);
        finish_test("read and write hits");

        run_request(1'b1, make_addr(23'h1234, 6'd5, 3'd0), 64'hffee_ddcc_bbaa_9988, 8'h5a,
                    1'b1, 1'b0, 1'b0, '0);
        run_request(1'b0, make_addr(23'h1234, 6'd5, 3'd0), '0, '0, 1'b1, 1'b0, 1'b0, '0);
        finish_test("partial write hit");

        // B ends up older than A, so C evicts B
        run_request(1'b1, make_addr(23'h0aa1, 6'd20, 3'd0), 64'haaaa_0000_1111_aaaa, 8'hff,
                    1'b0, 1'b1, 1'b0, '0);
        run_request(1'b1, make_addr(23'h0bb2, 6'd20, 3'd0), 64'hbbbb_2222_3333_bbbb, 8'hf0,
                    1'b0, 1'b1, 1'b0, '0);
        run_request(1'b0, make_addr(23'h0aa1, 6'd20, 3'd0), '0, '0, 1'b1, 1'b0, 1'b0, '0);
        run_request(1'b0, make_addr(23'h0cc3, 6'd20, 3'd0), '0, '0, 1'b0, 1'b1, 1'b1,
                    make_addr(23'h0bb2, 6'd20, 3'd0));
        run_request(1'b0, make_addr(23'h0bb2, 6'd20, 3'd0), '0, '0, 1'b0, 1'b1, 1'b1,
                    make_addr(23'h0aa1, 6'd20, 3'd0));
        finish_test("dirty eviction");

        for (int n = 0; n < RANDOM_REQS; n++) begin
            draw_bits(lfsr, 2, tag);
            draw_bits(lfsr, 2, set);
            draw_bits(lfsr, 3, offset);
            draw_bits(lfsr, 1, wr);
            draw_bits(lfsr, 32, lo);
            draw_bits(lfsr, 32, hi);
            draw_bits(lfsr, 8, strb);
            run_request(wr[0], make_addr(23'h2c0 + 23'(tag), 6'd40 + 6'(set), offset[2:0]),
                        {hi, lo}, strb[7:0], 1'b0, 1'b0, 1'b0, '0);
        end
        finish_test("random traffic");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tb.f
source/dcache_pkg.sv
source/dcache_way_if.sv
source/dcache_way.sv
source/dcache_way_select.sv
source/dcache_ctrl.sv
source/dcache_top.sv
tb/dcache_checker.sv
tb/dcache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f tb.f -o dcache_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/dcache_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1
